//--- hdl/sdSpi_defines.svh
`ifndef SD_SPI_DEFINES_SVH
`define SD_SPI_DEFINES_SVH

// Width of the SCLK half period counter
`define SD_DIV_WIDTH 6

// Half period lasts reload plus one clk cycles

// Slow rate for card identification, 64 cycles per half period
`define SD_SLOW_DIV 6'd63

// Fast rate for data phase, 2 cycles per half period
`define SD_FAST_DIV 6'd1

// Wishbone word addresses
// CTRL: write issues a control op, read gives status
`define SD_REG_CTRL 1'b0
// DATA: write starts a transfer, read gives last received byte
`define SD_REG_DATA 1'b1

`endif

//--- hdl/sdSpiPkg.sv
`default_nettype none

package sdSpiPkg;

   // Engine operation codes, also the CTRL write encoding
   typedef enum logic [2:0]
   {
      opNop      = 3'd0,
      opCsLow    = 3'd1,
      opCsHigh   = 3'd2,
      opFast     = 3'd3,
      opSlow     = 3'd4,
      opTransfer = 3'd5
   } spiOp_t;

   // Register block to engine, valid for one cycle
   typedef struct packed {
      spiOp_t     op;
      logic [7:0] txd;
   } spiCmd_t;

   // Engine state as seen on a CTRL read, busy in bit 2
   typedef struct packed {
      logic busy;
      logic csActive;
      logic fast;
   } spiStatus_t;

   // Host to slave half of the Wishbone bus
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic       adr;
      logic [7:0] dat;
   } wbReq_t;

   // Slave to host half
   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } wbRsp_t;

   // Card side outputs
   typedef struct packed {
      logic sclk;
      logic mosi;
      logic csN;
   } sdPins_t;

endpackage

`default_nettype wire

//--- hdl/sdSpiEngine.sv
`default_nettype none

`include "sdSpi_defines.svh"

module sdSpiEngine import sdSpiPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  spiCmd_t    cmd,
   input  logic       miso,
   output sdPins_t    pins,
   output logic [7:0] rxd,
   output spiStatus_t status,
   output logic       done
);

   // Engine states
   // Clock low and clock high alternate once per bit
   // Two tail half periods keep SCLK high before done
   typedef enum logic [2:0]
   {
      stReset,
      stIdle,
      stClkLow,
      stClkHigh,
      stTail1,
      stTail2
   } engState_t;

   engState_t                state;
   logic [`SD_DIV_WIDTH-1:0] divCnt;
   logic [`SD_DIV_WIDTH-1:0] divReload;
   logic [2:0]               bitCnt;
   logic [7:0]               txShift;
   logic [7:0]               rxShift;
   logic                     csN;
   logic                     fast;
   logic                     halfEnd;

   // Divisor picked by the current speed
   assign divReload = fast ? `SD_FAST_DIV : `SD_SLOW_DIV;

   // Last cycle of the current half period
   assign halfEnd = (divCnt == '0);

   ////////////////////////////////////////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= stReset;
         csN     <= 1'b1;
         fast    <= 1'b0;
         done    <= 1'b0;
         txShift <= 8'hff;
         rxd     <= 8'hff;
      end
      else
      begin
         // Done is a single cycle pulse
         done <= 1'b0;
         case (state)
            // Clear counters once before idle
            stReset:
            begin
               divCnt <= '0;
               bitCnt <= '0;
               state  <= stIdle;
            end

            // Control ops apply here
            // A transfer leaves idle
            stIdle:
            begin
               case (cmd.op)
                  opCsLow:
                     csN <= 1'b0;
                  opCsHigh:
                     csN <= 1'b1;
                  opFast:
                     fast <= 1'b1;
                  opSlow:
                     fast <= 1'b0;
                  opTransfer:
                  begin
                     // MSB goes out on MOSI as SCLK falls
                     divCnt  <= divReload;
                     bitCnt  <= 3'd7;
                     txShift <= cmd.txd;
                     state   <= stClkLow;
                  end
                  default:
                     state <= stIdle;
               endcase
            end

            // SCLK low with MISO sampled on the way out
            stClkLow:
            begin
               if (halfEnd)
               begin
                  divCnt  <= divReload;
                  rxShift <= {rxShift[6:0], miso};
                  state   <= stClkHigh;
               end
               else
                  divCnt <= divCnt - 1'b1;
            end

            // SCLK high with the next bit presented at its end
            stClkHigh:
            begin
               if (halfEnd)
               begin
                  divCnt <= divReload;
                  if (bitCnt == 3'd0)
                     state <= stTail1;
                  else
                  begin
                     txShift <= {txShift[6:0], 1'b1};
                     bitCnt  <= bitCnt - 1'b1;
                     state   <= stClkLow;
                  end
               end
               else
                  divCnt <= divCnt - 1'b1;
            end

            // First tail half period
            stTail1:
            begin
               if (halfEnd)
               begin
                  divCnt <= divReload;
                  state  <= stTail2;
               end
               else
                  divCnt <= divCnt - 1'b1;
            end

            // Second tail then publish the byte
            stTail2:
            begin
               if (halfEnd)
               begin
                  // MOSI back to idle high
                  txShift <= 8'hff;
                  rxd     <= rxShift;
                  done    <= 1'b1;
                  state   <= stIdle;
               end
               else
                  divCnt <= divCnt - 1'b1;
            end

            default:
               state <= stIdle;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////////////////////

   // SCLK low only in low half periods
   assign pins.sclk = (state != stClkLow);
   assign pins.mosi = txShift[7];
   assign pins.csN  = csN;

   assign status.busy     = (state != stIdle);
   assign status.csActive = !csN;
   assign status.fast     = fast;

   // Idle bus keeps MOSI parked high
   assert property (@(posedge clk) disable iff (rst) !status.busy |-> pins.mosi);

   // Completion is one cycle wide
   assert property (@(posedge clk) disable iff (rst) done |=> !done);

   // Register block must hold off while a transfer runs
   assert property (@(posedge clk) disable iff (rst) status.busy |-> cmd.op == opNop);

endmodule

`default_nettype wire

//--- hdl/sdSpiWbRegs.sv
`default_nettype none

`include "sdSpi_defines.svh"

module sdSpiWbRegs import sdSpiPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  wbReq_t     wbReq,
   output wbRsp_t     wbRsp,
   output spiCmd_t    cmd,
   input  spiStatus_t status,
   input  logic [7:0] rxd
);

   logic       reqValid;
   logic       rdReq;
   logic       wrReq;
   logic       wrIssue;
   logic       ackQ;
   logic [7:0] rdData;
   spiOp_t     ctrlOp;

   ////////////////////////////////////////////////////////////////////////////
   // Request decode
   ////////////////////////////////////////////////////////////////////////////

   // Open access not yet answered
   assign reqValid = wbReq.cyc && wbReq.stb && !ackQ;
   assign rdReq    = reqValid && !wbReq.we;
   assign wrReq    = reqValid && wbReq.we;

   // Writes stall until the engine is idle
   assign wrIssue = wrReq && !status.busy;

   // CTRL write op from low data bits
   // Transfer and unused codes fall back to nop
   always_comb
   begin
      case (wbReq.dat[2:0])
         opCsLow,
         opCsHigh,
         opFast,
         opSlow:
            ctrlOp = spiOp_t'(wbReq.dat[2:0]);
         default:
            ctrlOp = opNop;
      endcase
   end

   // One command per acknowledged write
   always_comb
   begin
      cmd.op  = opNop;
      cmd.txd = wbReq.dat;
      if (wrIssue)
      begin
         if (wbReq.adr == `SD_REG_DATA)
            cmd.op = opTransfer;
         else
            cmd.op = ctrlOp;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response
   ////////////////////////////////////////////////////////////////////////////

   // Ack one cycle after the access is taken
   always_ff @(posedge clk)
   begin
      if (rst)
         ackQ <= 1'b0;
      else
         ackQ <= rdReq || wrIssue;
   end

   // Read data captured with the request
   // Status in the low three bits for CTRL
   always_ff @(posedge clk)
   begin
      if (rdReq)
      begin
         if (wbReq.adr == `SD_REG_CTRL)
            rdData <= {5'b0, status};
         else
            rdData <= rxd;
      end
   end

   assign wbRsp.ack = ackQ;
   assign wbRsp.dat = rdData;

   // Master holds its request through the ack cycle
   assert property (@(posedge clk) disable iff (rst)
      ackQ |-> wbReq.cyc && wbReq.stb);

endmodule

`default_nettype wire

//--- hdl/sdSpiTop.sv
`default_nettype none

module sdSpiTop import sdSpiPkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  wbReq_t wbReq,
   output wbRsp_t wbRsp,
   input  logic   miso,
   output sdPins_t pins
);

   // Register block to engine
   spiCmd_t    cmd;
   // Engine back to register block
   spiStatus_t status;
   logic [7:0] rxd;

   // Wishbone slave, turns accesses into engine commands
   sdSpiWbRegs regs0
   (
      .clk    (clk),
      .rst    (rst),
      .wbReq  (wbReq),
      .wbRsp  (wbRsp),
      .cmd    (cmd),
      .status (status),
      .rxd    (rxd)
   );

   // Byte engine, drives the card pins
   // Completion reaches the host through status busy
   sdSpiEngine engine0
   (
      .clk    (clk),
      .rst    (rst),
      .cmd    (cmd),
      .miso   (miso),
      .pins   (pins),
      .rxd    (rxd),
      .status (status),
      .done   ()
   );

endmodule

`default_nettype wire

//--- sim/sdSpiSlaveModel.sv
`default_nettype none

// SPI mode 3 card, MISO changes after SCLK falls, MOSI taken as SCLK rises
module sdSpiSlaveModel
(
   input  logic sclk,
   input  logic mosi,
   input  logic csN,
   output logic miso
);

   // Bytes to send back, and bytes seen on MOSI
   logic [7:0] respQ[$];
   logic [7:0] capQ[$];
   logic [7:0] txByte;
   logic [7:0] rxByte;
   logic [2:0] bitIdx;
   logic       misoBit;

   initial
   begin
      txByte  = 8'hff;
      rxByte  = 8'h00;
      bitIdx  = 3'd0;
      misoBit = 1'b1;
   end

   // Released line reads high
   assign miso = csN ? 1'b1 : misoBit;

   // First falling edge of a byte loads the next response, empty queue sends ones
   always @(negedge sclk)
   begin
      if (!csN)
      begin
         if (bitIdx == 3'd0)
            txByte = (respQ.size() > 0) ? respQ.pop_front() : 8'hff;
         misoBit = txByte[3'd7 - bitIdx];
      end
   end

   // MSB first capture
   always @(posedge sclk)
   begin
      if (!csN)
      begin
         rxByte = {rxByte[6:0], mosi};
         if (bitIdx == 3'd7)
            capQ.push_back(rxByte);
         bitIdx = bitIdx + 3'd1;
      end
   end

   task automatic queueResponse(input logic [7:0] resp);
      respQ.push_back(resp);
   endtask

   function automatic int capturedCount();
      return capQ.size();
   endfunction

   function automatic logic [7:0] capturedByte(input int idx);
      return capQ[idx];
   endfunction

endmodule

`default_nettype wire

//--- sim/sdSpiTb.sv
`default_nettype none

`include "sdSpi_defines.svh"

module sdSpiTb import sdSpiPkg::*; ();

   localparam int ClkPeriod    = 20;
   localparam int FastCount    = 40;
   // Fast loop plus one slow and two back to back transfers
   localparam int XferCount    = FastCount + 3;
   localparam int HalfPeriods  = 18;
   localparam int SlowHalf     = `SD_SLOW_DIV + 1;
   localparam int FastXfer     = HalfPeriods * (`SD_FAST_DIV + 1);
   localparam int WatchdogTime = XferCount * HalfPeriods * SlowHalf * ClkPeriod + 200000;

   logic    clk;
   logic    rst;
   wbReq_t  wbReq;
   wbRsp_t  wbRsp;
   logic    miso;
   sdPins_t pins;

   // Reference model state
   logic       expCs;
   logic       expFast;
   logic [7:0] expRxd;
   logic [7:0] wrQ[$];
   int         errCount;
   int         checkCount;

   sdSpiTop dut0
   (
      .clk   (clk),
      .rst   (rst),
      .wbReq (wbReq),
      .wbRsp (wbRsp),
      .miso  (miso),
      .pins  (pins)
   );

   sdSpiSlaveModel card0
   (
      .sclk (pins.sclk),
      .mosi (pins.mosi),
      .csN  (pins.csN),
      .miso (miso)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(ClkPeriod / 2) clk = ~clk;
   end

   // Hard stop sized for every transfer at the slow rate
   initial
   begin
      #(WatchdogTime);
      $display("Timeout: the run did not finish in the expected time, a transfer never ended");
      $display("TEST FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic checkValue(input string testName, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      if (actual !== expected)
      begin
         errCount++;
         $display("Fail %s: expected %0h, actual %0h", testName, expected, actual);
      end
   endtask

   // Wishbone classic write held through the ack edge
   // Counts the cycles stalled before ack
   task automatic busWrite(input logic adr, input logic [7:0] dat, output int waitCycles);
      waitCycles = 0;
      @(negedge clk);
      wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
      @(negedge clk);
      while (!wbRsp.ack)
      begin
         waitCycles++;
         @(negedge clk);
      end
      @(negedge clk);
      wbReq = '0;
   endtask

   task automatic busRead(input logic adr, output logic [7:0] dat);
      @(negedge clk);
      wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
      @(negedge clk);
      while (!wbRsp.ack)
         @(negedge clk);
      dat = wbRsp.dat;
      @(negedge clk);
      wbReq = '0;
   endtask

   // Status word as the model sees it
   function automatic logic [7:0] expectedStatus(input logic busy);
      return {5'b0, busy, expCs, expFast};
   endfunction

   // Poll CTRL until busy drops
   task automatic waitIdle(output logic [7:0] st);
      do
         busRead(`SD_REG_CTRL, st);
      while (st[2]);
   endtask

   task automatic controlOp(input spiOp_t op);
      int         waitCycles;
      logic [7:0] st;
      busWrite(`SD_REG_CTRL, {5'b0, op}, waitCycles);
      case (op)
         opCsLow:  expCs = 1'b1;
         opCsHigh: expCs = 1'b0;
         opFast:   expFast = 1'b1;
         opSlow:   expFast = 1'b0;
         default:  expCs = expCs;
      endcase
      // Pins already updated in the ack cycle
      checkValue("ctrl csN", 32'(!expCs), 32'(pins.csN));
      busRead(`SD_REG_CTRL, st);
      checkValue("ctrl status", 32'(expectedStatus(1'b0)), 32'(st));
   endtask

   // Card gets its response queued before the byte goes out
   task automatic startTransfer(input logic [7:0] txd, input logic [7:0] resp,
                                output int waitCycles);
      card0.queueResponse(resp);
      wrQ.push_back(txd);
      expRxd = resp;
      busWrite(`SD_REG_DATA, txd, waitCycles);
   endtask

   task automatic finishTransfer(input string testName);
      logic [7:0] st;
      logic [7:0] rdVal;
      waitIdle(st);
      checkValue({testName, " status"}, 32'(expectedStatus(1'b0)), 32'(st));
      busRead(`SD_REG_DATA, rdVal);
      checkValue({testName, " rxd"}, 32'(expRxd), 32'(rdVal));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      int         waitCycles;
      int         lowCycles;
      logic [7:0] rdVal;
      logic [7:0] txd;
      logic [7:0] resp;
      wbReq      = '0;
      rst        = 1'b1;
      expCs      = 1'b0;
      expFast    = 1'b0;
      expRxd     = 8'hff;
      errCount   = 0;
      checkCount = 0;
      void'($urandom(32'h7594));
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Engine leaves its reset state first
      repeat (2) @(negedge clk);

      // Reset state
      checkValue("reset sclk", 32'd1, 32'(pins.sclk));
      checkValue("reset csN", 32'd1, 32'(pins.csN));
      busRead(`SD_REG_CTRL, rdVal);
      checkValue("reset status", 32'(expectedStatus(1'b0)), 32'(rdVal));
      busRead(`SD_REG_DATA, rdVal);
      checkValue("reset rxd", 32'hff, 32'(rdVal));

      // Chip select and speed ops
      controlOp(opCsLow);
      controlOp(opFast);
      controlOp(opCsHigh);
      controlOp(opSlow);

      // Random fast transfers
      controlOp(opCsLow);
      controlOp(opFast);
      for (int i = 0; i < FastCount; i++)
      begin
         txd  = 8'($urandom);
         resp = 8'($urandom);
         startTransfer(txd, resp, waitCycles);
         finishTransfer("fast");
      end

      // Slow rate measured on the second SCLK low phase
      controlOp(opSlow);
      startTransfer(8'($urandom), 8'($urandom), waitCycles);
      lowCycles = 0;
      while (pins.sclk == 1'b0)
         @(negedge clk);
      while (pins.sclk == 1'b1)
         @(negedge clk);
      while (pins.sclk == 1'b0)
      begin
         lowCycles++;
         @(negedge clk);
      end
      checkValue("slow low phase", 32'(SlowHalf), 32'(lowCycles));
      finishTransfer("slow");

      // Second write stalls behind the first
      controlOp(opFast);
      startTransfer(8'($urandom), 8'($urandom), waitCycles);
      busRead(`SD_REG_CTRL, rdVal);
      checkValue("stall busy", 32'(expectedStatus(1'b1)), 32'(rdVal));
      startTransfer(8'($urandom), 8'($urandom), waitCycles);
      checkValue("stall wait", 32'd1, 32'(waitCycles >= FastXfer / 2));
      finishTransfer("stall");
      controlOp(opCsHigh);

      // Card capture must match every byte written in order
      checkValue("capture count", 32'(wrQ.size()), 32'(card0.capturedCount()));
      for (int i = 0; i < wrQ.size(); i++)
         checkValue("capture byte", 32'(wrQ[i]), 32'(card0.capturedByte(i)));

      $display("Checks run %0d, errors %0d", checkCount, errCount);
      if (errCount == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sdSpiSys.f
+incdir+hdl
hdl/sdSpiPkg.sv
hdl/sdSpiEngine.sv
hdl/sdSpiWbRegs.sv
hdl/sdSpiTop.sv
sim/sdSpiSlaveModel.sv
sim/sdSpiTb.sv

//--- run.sh
#!/bin/sh
# Build the sdSpiSys testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module sdSpiTb -f sdSpiSys.f -o sdSpiSim

simOut=$(./obj_dir/sdSpiSim 2>&1 || true)
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx "TEST PASSED"; then
   exit 0
fi
exit 1
